// File: Makefile
TOP := tb_phy_mgmt

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/mdio_master.sv
// MDIO write master

`timescale 1ns/1ns

module mdio_master #(
    parameter int MDIO_PRESCALE = 3
) (
    input  logic                clk_125mhz_int,
    input  logic                gt_tx_reset,
    input  mdio_pkg::mdio_cmd_t cmd_i,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    output logic                mdc_o,
    output logic                mdio_o,
    output logic                mdio_oe_o
);

    import mdio_pkg::*;

    // ST + OP + PHYAD + REGAD + TA + DATA
    localparam int FRAME_W = 2 + 2 + MDIO_PHY_ADDR_W + MDIO_REG_ADDR_W + 2 + MDIO_DATA_W;
    localparam int BIT_CNT_W = $clog2((FRAME_W > MDIO_PREAMBLE_LEN) ? FRAME_W
                                                                     : MDIO_PREAMBLE_LEN);
    localparam int PRE_CNT_W = $clog2(MDIO_PRESCALE + 2);

    localparam logic [1:0] MDIO_START = 2'b01;
    localparam logic [1:0] MDIO_TA_WRITE = 2'b10;

    typedef enum logic [1:0] {
        MDIO_IDLE,
        MDIO_PREAMBLE,
        MDIO_FRAME
    } mdio_state_e;

    mdio_state_e state_q;
    logic [PRE_CNT_W-1:0] pre_cnt_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;
    logic [FRAME_W-1:0] frame_q;
    logic mdc_q;
    logic mdio_q;
    logic oe_q;

    logic half_end;
    logic bit_end;
    logic preamble_last;
    logic frame_last;
    logic shift_en;

    assign cmd_ready_o = (state_q == MDIO_IDLE);
    assign mdc_o = mdc_q;
    assign mdio_o = mdio_q;
    assign mdio_oe_o = oe_q;

    assign half_end = (pre_cnt_q == PRE_CNT_W'(MDIO_PRESCALE));
    // a bit period closes on the falling edge of mdc
    assign bit_end = (state_q != MDIO_IDLE) && mdc_q && half_end;
    assign preamble_last = (state_q == MDIO_PREAMBLE) &&
                           (bit_cnt_q == BIT_CNT_W'(MDIO_PREAMBLE_LEN - 1));
    assign frame_last = (state_q == MDIO_FRAME) && (bit_cnt_q == BIT_CNT_W'(FRAME_W - 1));
    assign shift_en = bit_end && (preamble_last || (state_q == MDIO_FRAME));

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state_q <= MDIO_IDLE;
            pre_cnt_q <= '0;
            bit_cnt_q <= '0;
            mdc_q <= 1'b0;
            mdio_q <= 1'b1;
            oe_q <= 1'b0;
        end else if (state_q == MDIO_IDLE) begin
            if (cmd_valid_i) begin
                // first preamble bit goes out right away
                state_q <= MDIO_PREAMBLE;
                pre_cnt_q <= '0;
                bit_cnt_q <= '0;
                mdc_q <= 1'b0;
                mdio_q <= 1'b1;
                oe_q <= 1'b1;
            end
        end else if (half_end) begin
            pre_cnt_q <= '0;
            mdc_q <= ~mdc_q;
            if (bit_end) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
                if (preamble_last) begin
                    state_q <= MDIO_FRAME;
                    bit_cnt_q <= '0;
                    mdio_q <= frame_q[FRAME_W-1];
                end else if (frame_last) begin
                    state_q <= MDIO_IDLE;
                    mdio_q <= 1'b1;
                    oe_q <= 1'b0;
                end else if (state_q == MDIO_FRAME) begin
                    mdio_q <= frame_q[FRAME_W-1];
                end
            end
        end else begin
            pre_cnt_q <= pre_cnt_q + 1'b1;
        end
    end

    // frame shifter, msb leaves first
    always_ff @(posedge clk_125mhz_int) begin
        if (cmd_valid_i && cmd_ready_o) begin
            frame_q <= {MDIO_START, cmd_i.opcode, cmd_i.phy_addr, cmd_i.reg_addr,
                        MDIO_TA_WRITE, cmd_i.data};
        end else if (shift_en) begin
            frame_q <= {frame_q[FRAME_W-2:0], 1'b0};
        end
    end

endmodule

// File: logic/mdio_pkg.sv
// MDIO management frame types

package mdio_pkg;

    // clause 22 field widths
    localparam int MDIO_PHY_ADDR_W = 5;
    localparam int MDIO_REG_ADDR_W = 5;
    localparam int MDIO_DATA_W = 16;

    // number of ones sent ahead of the start pattern
    localparam int MDIO_PREAMBLE_LEN = 32;

    // clause 22 opcodes
    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ = 2'b10
    } mdio_op_e;

    // one management command, as handed from sequencer to master
    typedef struct packed {
        logic [MDIO_PHY_ADDR_W-1:0] phy_addr;
        logic [MDIO_REG_ADDR_W-1:0] reg_addr;
        logic [MDIO_DATA_W-1:0] data;
        mdio_op_e opcode;
    } mdio_cmd_t;

endpackage

// File: logic/phy_init_pkg.sv
// PHY init sequence definitions

package phy_init_pkg;

    // indirect access registers of the PHY
    localparam logic [mdio_pkg::MDIO_REG_ADDR_W-1:0] REGCR_ADDR = 5'h0D;
    localparam logic [mdio_pkg::MDIO_REG_ADDR_W-1:0] ADDAR_ADDR = 5'h0E;

    // REGCR values: devad 1f, address function then data function
    localparam logic [mdio_pkg::MDIO_DATA_W-1:0] REGCR_SEL_ADDR = 16'h001F;
    localparam logic [mdio_pkg::MDIO_DATA_W-1:0] REGCR_SEL_DATA = 16'h401F;

    // one extended register write
    typedef struct packed {
        logic [mdio_pkg::MDIO_DATA_W-1:0] ext_reg;
        logic [mdio_pkg::MDIO_DATA_W-1:0] ext_data;
    } ext_write_t;

    localparam int EXT_WRITE_COUNT = 3;

    // CFG4: sgmii autoneg timer to 11 ms
    // SGMIICTL1: sgmii clock output on
    // 10M_SGMII_CFG: allow 10 Mbps operation
    localparam ext_write_t EXT_WRITES [EXT_WRITE_COUNT] = '{
        '{ext_reg: 16'h0031, ext_data: 16'h0070},
        '{ext_reg: 16'h00D3, ext_data: 16'h4000},
        '{ext_reg: 16'h016F, ext_data: 16'h0015}
    };

    // sequencer states
    typedef enum logic [1:0] {
        INIT_WAIT,
        INIT_ISSUE,
        INIT_DONE
    } init_state_e;

    // count of accepted commands, four per extended write
    typedef logic [3:0] init_step_t;

endpackage

// File: logic/phy_init_seq.sv
// PHY init command sequencer

`timescale 1ns/1ns

module phy_init_seq #(
    parameter logic [mdio_pkg::MDIO_PHY_ADDR_W-1:0] PHY_ADDR = 5'h03,
    parameter int STARTUP_DELAY = 1000000
) (
    input  logic                     clk_125mhz_int,
    input  logic                     gt_tx_reset,
    output mdio_pkg::mdio_cmd_t      cmd_o,
    output logic                     cmd_valid_o,
    input  logic                     cmd_ready_i,
    output phy_init_pkg::init_step_t step_o,
    output logic                     init_done_o
);

    import mdio_pkg::*;
    import phy_init_pkg::*;

    localparam int DELAY_W = (STARTUP_DELAY > 1) ? $clog2(STARTUP_DELAY) : 1;
    localparam int STEP_COUNT = 4 * EXT_WRITE_COUNT;

    init_state_e state_q;
    logic [DELAY_W-1:0] delay_q;
    init_step_t step_q;
    ext_write_t ext_sel;
    logic cmd_accept;

    assign cmd_valid_o = (state_q == INIT_ISSUE);
    assign cmd_accept = cmd_valid_o && cmd_ready_i;
    assign init_done_o = (state_q == INIT_DONE);
    assign step_o = step_q;

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state_q <= INIT_WAIT;
            delay_q <= DELAY_W'(STARTUP_DELAY - 1);
            step_q <= '0;
        end else begin
            case (state_q)
                INIT_WAIT: begin
                    // give the PHY time to come out of its own reset
                    if (delay_q == '0) begin
                        state_q <= INIT_ISSUE;
                    end else begin
                        delay_q <= delay_q - 1'b1;
                    end
                end
                INIT_ISSUE: begin
                    if (cmd_accept) begin
                        step_q <= step_q + 1'b1;
                        if (step_q == init_step_t'(STEP_COUNT - 1)) begin
                            state_q <= INIT_DONE;
                        end
                    end
                end
                default: begin
                    state_q <= INIT_DONE;
                end
            endcase
        end
    end

    // upper step bits pick the table entry, lower bits the phase
    always_comb begin
        ext_sel = '0;
        if (step_q[3:2] < EXT_WRITE_COUNT) begin
            ext_sel = EXT_WRITES[step_q[3:2]];
        end

        cmd_o.phy_addr = PHY_ADDR;
        cmd_o.opcode = MDIO_OP_WRITE;

        case (step_q[1:0])
            2'd0: begin
                cmd_o.reg_addr = REGCR_ADDR;
                cmd_o.data = REGCR_SEL_ADDR;
            end
            2'd1: begin
                cmd_o.reg_addr = ADDAR_ADDR;
                cmd_o.data = ext_sel.ext_reg;
            end
            2'd2: begin
                cmd_o.reg_addr = REGCR_ADDR;
                cmd_o.data = REGCR_SEL_DATA;
            end
            default: begin
                cmd_o.reg_addr = ADDAR_ADDR;
                cmd_o.data = ext_sel.ext_data;
            end
        endcase
    end

endmodule

// File: logic/phy_mgmt_top.sv
// PHY management top level

`timescale 1ns/1ns

module phy_mgmt_top #(
    parameter logic [mdio_pkg::MDIO_PHY_ADDR_W-1:0] PHY_ADDR = 5'h03,
    parameter int STARTUP_DELAY = 1000000,
    parameter int MDIO_PRESCALE = 3,
    parameter int DEBOUNCE_RATE = 125000,
    parameter int NUM_SAMPLES = 4
) (
    input  logic       clk_125mhz_int,
    input  logic       gt_tx_reset,
    input  logic [3:0] sw_i,
    input  logic [7:0] block_lock_i,
    output logic [7:0] led_o,
    output logic       mdc_o,
    output logic       mdio_o,
    output logic       mdio_oe_o,
    output logic       init_done_o
);

    import mdio_pkg::*;
    import phy_init_pkg::*;

    logic [3:0] sw_db;
    mdio_cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;
    init_step_t step;

    switch_debounce #(
        .WIDTH         (4),
        .NUM_SAMPLES   (NUM_SAMPLES),
        .DEBOUNCE_RATE (DEBOUNCE_RATE)
    ) i_switch_debounce (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .sw_i           (sw_i),
        .sw_o           (sw_db)
    );

    phy_init_seq #(
        .PHY_ADDR      (PHY_ADDR),
        .STARTUP_DELAY (STARTUP_DELAY)
    ) i_phy_init_seq (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .cmd_o          (cmd),
        .cmd_valid_o    (cmd_valid),
        .cmd_ready_i    (cmd_ready),
        .step_o         (step),
        .init_done_o    (init_done_o)
    );

    mdio_master #(
        .MDIO_PRESCALE (MDIO_PRESCALE)
    ) i_mdio_master (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .cmd_i          (cmd),
        .cmd_valid_i    (cmd_valid),
        .cmd_ready_o    (cmd_ready),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_oe_o      (mdio_oe_o)
    );

    // switch 0 shows lane block lock, otherwise init progress
    assign led_o = sw_db[0] ? block_lock_i : {init_done_o, 3'b000, step};

endmodule

// File: logic/switch_debounce.sv
// Switch debouncer

`timescale 1ns/1ns

module switch_debounce #(
    parameter int WIDTH = 4,
    parameter int NUM_SAMPLES = 4,
    parameter int DEBOUNCE_RATE = 125000
) (
    input  logic             clk_125mhz_int,
    input  logic             gt_tx_reset,
    input  logic [WIDTH-1:0] sw_i,
    output logic [WIDTH-1:0] sw_o
);

    localparam int RATE_W = $clog2(DEBOUNCE_RATE + 1);

    logic [RATE_W-1:0] rate_cnt_q;
    logic sample_tick;

    // sample history per switch, newest sample in bit 0
    logic [NUM_SAMPLES-1:0] hist_q [WIDTH];

    assign sample_tick = (rate_cnt_q == RATE_W'(DEBOUNCE_RATE - 1));

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rate_cnt_q <= '0;
        end else if (sample_tick) begin
            rate_cnt_q <= '0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            for (int i = 0; i < WIDTH; i++) begin
                hist_q[i] <= '0;
            end
            sw_o <= '0;
        end else if (sample_tick) begin
            for (int i = 0; i < WIDTH; i++) begin
                hist_q[i] <= (hist_q[i] << 1) | NUM_SAMPLES'(sw_i[i]);
                // only move when the whole history agrees
                if (&hist_q[i]) begin
                    sw_o[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    sw_o[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: sim.f
logic/mdio_pkg.sv
logic/phy_init_pkg.sv
logic/switch_debounce.sv
logic/phy_init_seq.sv
logic/mdio_master.sv
logic/phy_mgmt_top.sv
tb/mdio_phy_model.sv
tb/tb_phy_mgmt.sv

// File: tb/mdio_phy_model.sv
// MDIO PHY side frame decoder

`timescale 1ns/1ns

module mdio_phy_model (
    input  logic                clk_125mhz_int,
    input  logic                gt_tx_reset,
    input  logic                mdc_i,
    input  logic                mdio_i,
    input  logic                mdio_oe_i,
    output mdio_pkg::mdio_cmd_t frame_o,
    output logic                preamble_ok_o,
    output logic                ta_ok_o,
    output logic                frame_valid_o
);

    import mdio_pkg::*;

    // preamble, then ST OP PHYAD REGAD TA DATA
    localparam int FRAME_BITS = MDIO_PREAMBLE_LEN + 32;

    logic mdc_d;
    logic [FRAME_BITS-1:0] bits_q;
    logic [FRAME_BITS-1:0] next_bits;
    int bit_cnt;

    assign next_bits = {bits_q[FRAME_BITS-2:0], mdio_i};

    always @(posedge clk_125mhz_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            mdc_d <= 1'b0;
            bits_q <= '0;
            bit_cnt <= 0;
            frame_o <= '0;
            preamble_ok_o <= 1'b0;
            ta_ok_o <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            mdc_d <= mdc_i;
            frame_valid_o <= 1'b0;
            if (!mdio_oe_i) begin
                bit_cnt <= 0;
            end else if (mdc_i && !mdc_d) begin
                // rising mdc, data is stable here
                bits_q <= next_bits;
                if (bit_cnt == FRAME_BITS - 1) begin
                    bit_cnt <= 0;
                    // all ones followed by the 01 start pattern
                    preamble_ok_o <= (&next_bits[63:32]) && (next_bits[31:30] == 2'b01);
                    frame_o.opcode <= mdio_op_e'(next_bits[29:28]);
                    frame_o.phy_addr <= next_bits[27:23];
                    frame_o.reg_addr <= next_bits[22:18];
                    ta_ok_o <= (next_bits[17:16] == 2'b10);
                    frame_o.data <= next_bits[15:0];
                    frame_valid_o <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1;
                end
            end
        end
    end

endmodule

// File: tb/tb_phy_mgmt.sv
// PHY management testbench

`timescale 1ns/1ns

module tb_phy_mgmt;

    import mdio_pkg::*;
    import phy_init_pkg::*;

    localparam logic [MDIO_PHY_ADDR_W-1:0] PHY_ADDR = 5'h03;
    localparam int STARTUP_DELAY = 20;
    localparam int MDIO_PRESCALE = 1;
    localparam int DEBOUNCE_RATE = 4;
    localparam int NUM_SAMPLES = 3;

    localparam int FRAME_COUNT = 4 * EXT_WRITE_COUNT;
    localparam int FRAME_CYCLES = 64 * 2 * (MDIO_PRESCALE + 1) + 2;
    localparam int TIMEOUT_CYCLES = 2 * (STARTUP_DELAY + FRAME_COUNT * FRAME_CYCLES + 200);
    localparam int QUIET_CYCLES = 2000;
    localparam int SETTLE_CYCLES = 40;
    localparam int LED_STEPS = 3;

    typedef struct packed {
        logic [3:0] sw;
        logic [7:0] led;
    } led_check_t;

    logic clk_125mhz_int;
    logic gt_tx_reset;
    logic [3:0] sw_i;
    logic [7:0] block_lock_i;
    logic [7:0] led_o;
    logic mdc_o;
    logic mdio_o;
    logic mdio_oe_o;
    logic init_done_o;

    mdio_cmd_t rx_frame;
    logic rx_preamble_ok;
    logic rx_ta_ok;
    logic rx_frame_valid;

    mdio_cmd_t expected_frames [FRAME_COUNT];
    led_check_t led_table [LED_STEPS];
    integer seed;
    logic [31:0] rand_word;
    int cycle_cnt = 0;
    int phase_len = 0;
    logic mdc_prev = 1'b0;

    phy_mgmt_top #(
        .PHY_ADDR      (PHY_ADDR),
        .STARTUP_DELAY (STARTUP_DELAY),
        .MDIO_PRESCALE (MDIO_PRESCALE),
        .DEBOUNCE_RATE (DEBOUNCE_RATE),
        .NUM_SAMPLES   (NUM_SAMPLES)
    ) i_phy_mgmt_top (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .sw_i           (sw_i),
        .block_lock_i   (block_lock_i),
        .led_o          (led_o),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_oe_o      (mdio_oe_o),
        .init_done_o    (init_done_o)
    );

    mdio_phy_model i_mdio_phy_model (
        .clk_125mhz_int (clk_125mhz_int),
        .gt_tx_reset    (gt_tx_reset),
        .mdc_i          (mdc_o),
        .mdio_i         (mdio_o),
        .mdio_oe_i      (mdio_oe_o),
        .frame_o        (rx_frame),
        .preamble_ok_o  (rx_preamble_ok),
        .ta_ok_o        (rx_ta_ok),
        .frame_valid_o  (rx_frame_valid)
    );

    always #4 clk_125mhz_int = ~clk_125mhz_int;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    function automatic mdio_cmd_t write_cmd(input logic [4:0] reg_addr, input logic [15:0] data);
        mdio_cmd_t cmd;
        cmd.phy_addr = PHY_ADDR;
        cmd.reg_addr = reg_addr;
        cmd.data = data;
        cmd.opcode = MDIO_OP_WRITE;
        return cmd;
    endfunction

    // four clause 22 writes per extended register
    task automatic build_expected_table();
        for (int i = 0; i < EXT_WRITE_COUNT; i++) begin
            expected_frames[4*i] = write_cmd(REGCR_ADDR, REGCR_SEL_ADDR);
            expected_frames[4*i+1] = write_cmd(ADDAR_ADDR, EXT_WRITES[i].ext_reg);
            expected_frames[4*i+2] = write_cmd(REGCR_ADDR, REGCR_SEL_DATA);
            expected_frames[4*i+3] = write_cmd(ADDAR_ADDR, EXT_WRITES[i].ext_data);
        end
    endtask

    always @(posedge clk_125mhz_int) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout: run did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    // mdc half periods while a frame is on the wire
    always @(negedge clk_125mhz_int) begin
        if (!gt_tx_reset) begin
            if (mdio_oe_o) begin
                if (phase_len == 0) begin
                    phase_len = 1;
                end else if (mdc_o != mdc_prev) begin
                    assert (phase_len == MDIO_PRESCALE + 1) else
                        report_failure($sformatf(
                            "CHECK FAILED mdc_o phase length: got %h expected %h",
                            phase_len, MDIO_PRESCALE + 1));
                    phase_len = 1;
                end else begin
                    phase_len = phase_len + 1;
                end
            end else begin
                if (phase_len != 0) begin
                    assert (phase_len == MDIO_PRESCALE + 1) else
                        report_failure($sformatf(
                            "CHECK FAILED mdc_o phase length: got %h expected %h",
                            phase_len, MDIO_PRESCALE + 1));
                end
                phase_len = 0;
            end
            mdc_prev = mdc_o;
        end
    end

    task automatic check_startup_idle();
        for (int i = 0; i < STARTUP_DELAY; i++) begin
            @(negedge clk_125mhz_int);
            assert (!mdc_o && !mdio_oe_o && !init_done_o) else
                report_failure($sformatf(
                    "CHECK FAILED mdc_o/mdio_oe_o/init_done_o: got %h%h%h expected 000",
                    mdc_o, mdio_oe_o, init_done_o));
        end
    endtask

    task automatic receive_frames();
        for (int f = 0; f < FRAME_COUNT; f++) begin
            @(negedge clk_125mhz_int);
            while (!rx_frame_valid) begin
                @(negedge clk_125mhz_int);
            end
            assert (rx_frame.opcode == expected_frames[f].opcode) else
                report_failure($sformatf("CHECK FAILED opcode frame %0d: got %h expected %h",
                                         f, rx_frame.opcode, expected_frames[f].opcode));
            assert (rx_frame.phy_addr == expected_frames[f].phy_addr) else
                report_failure($sformatf("CHECK FAILED phy_addr frame %0d: got %h expected %h",
                                         f, rx_frame.phy_addr, expected_frames[f].phy_addr));
            assert (rx_frame.reg_addr == expected_frames[f].reg_addr) else
                report_failure($sformatf("CHECK FAILED reg_addr frame %0d: got %h expected %h",
                                         f, rx_frame.reg_addr, expected_frames[f].reg_addr));
            assert (rx_frame.data == expected_frames[f].data) else
                report_failure($sformatf("CHECK FAILED data frame %0d: got %h expected %h",
                                         f, rx_frame.data, expected_frames[f].data));
            assert (rx_preamble_ok && rx_ta_ok) else
                report_failure($sformatf("frame %0d has a bad preamble, start or turnaround", f));
        end
    endtask

    task automatic check_quiet_after_done();
        assert (init_done_o) else
            report_failure($sformatf("CHECK FAILED init_done_o: got %h expected 1", init_done_o));
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk_125mhz_int);
            assert (!rx_frame_valid) else
                report_failure("an extra MDIO frame appeared after init was done");
        end
    endtask

    task automatic check_leds();
        for (int i = 0; i < LED_STEPS; i++) begin
            @(posedge clk_125mhz_int);
            #1 sw_i = led_table[i].sw;
            repeat (SETTLE_CYCLES) @(negedge clk_125mhz_int);
            assert (led_o == led_table[i].led) else
                report_failure($sformatf("CHECK FAILED led_o step %0d: got %h expected %h",
                                         i, led_o, led_table[i].led));
        end
    endtask

    initial begin
        clk_125mhz_int = 1'b0;
        seed = 32'h3fc7;
        rand_word = $random(seed);
        gt_tx_reset = 1'b1;
        sw_i = 4'h0;
        block_lock_i = rand_word[7:0];
        build_expected_table();

        // done flag in bit 7 and final step count in the low nibble
        led_table[0] = '{sw: 4'h0, led: 8'h80 | 8'(FRAME_COUNT)};
        led_table[1] = '{sw: 4'h1, led: rand_word[7:0]};
        led_table[2] = '{sw: 4'h0, led: 8'h80 | 8'(FRAME_COUNT)};

        repeat (8) @(posedge clk_125mhz_int);
        #1 gt_tx_reset = 1'b0;

        check_startup_idle();
        receive_frames();
        check_quiet_after_done();
        check_leds();

        $display("Everything OK");
        $finish;
    end

endmodule
